// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pcs_pattern
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== data_generator.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module data_generator (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,
	output pcs_pattern_pkg::block_t o_data_block,
	output logic                    o_data_valid
);
	import pcs_pattern_pkg::*;

	localparam int NB_LANES = `PCS_NB_DATA / `PCS_NB_BYTE;

	localparam lfsr_t LANE_SEED [NB_LANES] = '{
		11'h7FE,
		11'h7BE,
		11'h2AA,
		11'h4ED,
		11'h3AA,
		11'h7AE,
		11'h5CA,
		11'h2DC
	};

	localparam int LANE_HIGH [NB_LANES] = '{10, 7, 9, 10, 10, 8, 10, 9};
	localparam int LANE_LOW  [NB_LANES] = '{3, 0, 2, 3, 3, 1, 3, 2};

	byte_t lane_byte [NB_LANES];

	for (genvar k = 0; k < NB_LANES; k++) begin : g_lane
		prbs11_lane #(
			.SEED     (LANE_SEED[k]),
			.HIGH_LIM (LANE_HIGH[k]),
			.LOW_LIM  (LANE_LOW[k])
		) u_prbs11 (
			.i_clock    (i_clock),
			.i_reset    (i_reset),
			.i_enable   (i_enable),
			.o_sequence (lane_byte[k])
		);
	end

	// Byte k of the block comes from lane k
	always_comb begin
		for (int i = 0; i < NB_LANES; i++) begin
			o_data_block[i*`PCS_NB_BYTE +: `PCS_NB_BYTE] = lane_byte[i];
		end
	end

	// Lanes show their advanced state one edge after the enable
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data_valid <= 1'b0;
		end else begin
			o_data_valid <= i_enable;
		end
	end

endmodule

// ==== pattern_checker.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module pattern_checker (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  pcs_pattern_pkg::block_t i_data_block,
	input  pcs_pattern_pkg::sync_t  i_sync,
	input  logic                    i_data_valid,
	output logic                    o_locked,
	output pcs_pattern_pkg::count_t o_err_blocks,
	output pcs_pattern_pkg::count_t o_err_bits,
	output pcs_pattern_pkg::count_t o_hdr_errors
);
	import pcs_pattern_pkg::*;

	localparam int RUN_MAX = (`PCS_LOCK_GOOD > `PCS_LOCK_BAD) ? `PCS_LOCK_GOOD : `PCS_LOCK_BAD;
	localparam int RUN_W   = $clog2(RUN_MAX + 1);

	block_t            gen_block;
	logic              gen_valid;
	block_t            rx_block_q;
	sync_t             rx_sync_q;
	block_t            err_mask;
	count_t            err_bit_cnt;
	logic              hdr_good;
	lock_state_t       lock_state;
	logic [RUN_W-1:0]  hdr_run;

	function automatic count_t sat_add(input count_t acc, input count_t inc);
		logic [$bits(count_t):0] sum;
		sum = {1'b0, acc} + {1'b0, inc};
		return sum[$bits(count_t)] ? '1 : sum[$bits(count_t)-1:0];
	endfunction

	// Steps once per received block, so its output trails the input by one edge
	data_generator u_local_gen (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_enable     (i_data_valid),
		.o_data_block (gen_block),
		.o_data_valid (gen_valid)
	);

	always_ff @(posedge i_clock) begin
		if (i_data_valid) begin
			rx_block_q <= i_data_block; // Aligns with the local generator
			rx_sync_q  <= i_sync;
		end
	end

	assign err_mask    = rx_block_q ^ gen_block;
	assign err_bit_cnt = count_t'($countones(err_mask));
	assign hdr_good    = (rx_sync_q == `PCS_SYNC_DATA);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_err_blocks <= '0;
			o_err_bits   <= '0;
			o_hdr_errors <= '0;
		end else if (gen_valid) begin
			o_err_bits   <= sat_add(o_err_bits, err_bit_cnt);
			o_err_blocks <= sat_add(o_err_blocks, count_t'(|err_mask));
			o_hdr_errors <= sat_add(o_hdr_errors, count_t'(!hdr_good));
		end
	end

	// One run counter serves both states and restarts on every state change
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			lock_state <= LOCK_HUNT;
			hdr_run    <= '0;
		end else if (gen_valid) begin
			case (lock_state)
				LOCK_HUNT: begin
					if (!hdr_good) begin
						hdr_run <= '0;
					end else if (hdr_run == RUN_W'(`PCS_LOCK_GOOD - 1)) begin
						lock_state <= LOCK_LOCKED;
						hdr_run    <= '0;
					end else begin
						hdr_run <= hdr_run + 1'b1;
					end
				end
				LOCK_LOCKED: begin
					if (hdr_good) begin
						hdr_run <= '0;
					end else if (hdr_run == RUN_W'(`PCS_LOCK_BAD - 1)) begin
						lock_state <= LOCK_HUNT;
						hdr_run    <= '0;
					end else begin
						hdr_run <= hdr_run + 1'b1;
					end
				end
				default: begin
					lock_state <= LOCK_HUNT;
					hdr_run    <= '0;
				end
			endcase
		end
	end

	assign o_locked = (lock_state == LOCK_LOCKED);

endmodule

// ==== pcs_descrambler.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module pcs_descrambler (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  pcs_pattern_pkg::coded_t i_rx_block,
	input  logic                    i_rx_valid,
	output pcs_pattern_pkg::block_t o_data_block,
	output pcs_pattern_pkg::sync_t  o_sync,
	output logic                    o_data_valid
);
	import pcs_pattern_pkg::*;

	scr_state_t dsc_state;
	scr_state_t dsc_state_next;
	block_t     rx_payload;
	block_t     dsc_data;

	assign rx_payload = i_rx_block[`PCS_NB_CODED-1:`PCS_NB_CODED-`PCS_NB_DATA];

	// The received bit enters the state, so a line error heals after the last tap
	always_comb begin
		dsc_state_next = dsc_state;
		for (int i = 0; i < `PCS_NB_DATA; i++) begin
			dsc_data[i] = rx_payload[i] ^ dsc_state_next[`PCS_SCR_TAP] ^
				dsc_state_next[`PCS_SCR_LEN-1];
			dsc_state_next = {dsc_state_next[`PCS_SCR_LEN-2:0], rx_payload[i]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			dsc_state    <= '1;
			o_data_valid <= 1'b0;
		end else begin
			o_data_valid <= i_rx_valid;
			if (i_rx_valid) begin
				dsc_state <= dsc_state_next;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rx_valid) begin
			o_data_block <= dsc_data;
			o_sync       <= i_rx_block[`PCS_NB_CODED-`PCS_NB_DATA-1:0]; // Header is not checked here
		end
	end

endmodule

// ==== pcs_pattern_pkg.sv ====
`include "pcs_pattern_settings.svh"

package pcs_pattern_pkg;

	typedef logic [`PCS_NB_BYTE-1:0] byte_t;

	typedef logic [`PCS_NB_DATA-1:0] block_t;

	typedef logic [`PCS_NB_CODED-1:0] coded_t; // Header sits in the two low bits

	typedef logic [`PCS_NB_CODED-`PCS_NB_DATA-1:0] sync_t;

	typedef logic [`PCS_PRBS_LEN-1:0] lfsr_t;

	typedef logic [`PCS_SCR_LEN-1:0] scr_state_t;

	typedef logic [`PCS_NB_COUNT-1:0] count_t; // Saturates at all ones

	typedef enum logic {
		LOCK_HUNT,
		LOCK_LOCKED
	} lock_state_t;

endpackage

// ==== pcs_pattern_settings.svh ====
`ifndef PCS_PATTERN_SETTINGS_SVH
`define PCS_PATTERN_SETTINGS_SVH

// Block geometry
`define PCS_NB_BYTE 8
`define PCS_NB_DATA 64
`define PCS_NB_CODED 66
`define PCS_NB_COUNT 32

// Only the data sync header is generated or accepted
`define PCS_SYNC_DATA 2'b01

// PRBS11 lanes use x^11 + x^9 + 1
`define PCS_PRBS_LEN 11

// Scrambler polynomial x^58 + x^39 + 1, taps on state bits 38 and 57
`define PCS_SCR_LEN 58
`define PCS_SCR_TAP 38

// Header lock hysteresis in blocks
`define PCS_LOCK_GOOD 8
`define PCS_LOCK_BAD 4

`endif

// ==== pcs_pattern_sva.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module pcs_pattern_sva (
	input logic                    i_clock,
	input logic                    i_reset,
	input logic                    i_enable,
	input pcs_pattern_pkg::coded_t o_tx_block,
	input logic                    o_tx_valid,
	input pcs_pattern_pkg::count_t o_err_blocks,
	input pcs_pattern_pkg::count_t o_err_bits,
	input pcs_pattern_pkg::count_t o_hdr_errors
);
	import pcs_pattern_pkg::*;

	// Generator register plus scrambler register
	a_tx_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		o_tx_valid == $past(i_enable, 2))
		else $error("o_tx_valid does not follow i_enable by two cycles");

	a_tx_header: assert property (@(posedge i_clock) disable iff (i_reset)
		o_tx_valid |-> o_tx_block[1:0] == `PCS_SYNC_DATA)
		else $error("o_tx_block carries a sync header other than 01");

	a_counters_grow: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_err_blocks >= $past(o_err_blocks)) && (o_err_bits >= $past(o_err_bits)) &&
		(o_hdr_errors >= $past(o_hdr_errors)))
		else $error("an error counter decreased");

endmodule

bind pcs_pattern_top pcs_pattern_sva sva_i (
	.i_clock      (i_clock),
	.i_reset      (i_reset),
	.i_enable     (i_enable),
	.o_tx_block   (o_tx_block),
	.o_tx_valid   (o_tx_valid),
	.o_err_blocks (o_err_blocks),
	.o_err_bits   (o_err_bits),
	.o_hdr_errors (o_hdr_errors)
);

// ==== pcs_pattern_top.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module pcs_pattern_top (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,
	input  pcs_pattern_pkg::coded_t i_rx_block,
	input  logic                    i_rx_valid,
	output pcs_pattern_pkg::coded_t o_tx_block,
	output logic                    o_tx_valid,
	output logic                    o_locked,
	output pcs_pattern_pkg::count_t o_err_blocks,
	output pcs_pattern_pkg::count_t o_err_bits,
	output pcs_pattern_pkg::count_t o_hdr_errors
);
	import pcs_pattern_pkg::*;

	block_t tx_data;
	logic   tx_data_valid;
	block_t rx_data;
	sync_t  rx_sync;
	logic   rx_data_valid;

	data_generator u_data_generator (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_enable     (i_enable),
		.o_data_block (tx_data),
		.o_data_valid (tx_data_valid)
	);

	pcs_scrambler u_pcs_scrambler (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_data_block (tx_data),
		.i_data_valid (tx_data_valid),
		.o_tx_block   (o_tx_block),
		.o_tx_valid   (o_tx_valid)
	);

	pcs_descrambler u_pcs_descrambler (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_rx_block   (i_rx_block),
		.i_rx_valid   (i_rx_valid),
		.o_data_block (rx_data),
		.o_sync       (rx_sync),
		.o_data_valid (rx_data_valid)
	);

	pattern_checker u_pattern_checker (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_data_block (rx_data),
		.i_sync       (rx_sync),
		.i_data_valid (rx_data_valid),
		.o_locked     (o_locked),
		.o_err_blocks (o_err_blocks),
		.o_err_bits   (o_err_bits),
		.o_hdr_errors (o_hdr_errors)
	);

endmodule

// ==== pcs_scrambler.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module pcs_scrambler (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  pcs_pattern_pkg::block_t i_data_block,
	input  logic                    i_data_valid,
	output pcs_pattern_pkg::coded_t o_tx_block,
	output logic                    o_tx_valid
);
	import pcs_pattern_pkg::*;

	scr_state_t scr_state;
	scr_state_t scr_state_next;
	block_t     scr_data;

	// Bit 0 goes through the scrambler first and the output is fed back
	always_comb begin
		scr_state_next = scr_state;
		for (int i = 0; i < `PCS_NB_DATA; i++) begin
			scr_data[i] = i_data_block[i] ^ scr_state_next[`PCS_SCR_TAP] ^
				scr_state_next[`PCS_SCR_LEN-1];
			scr_state_next = {scr_state_next[`PCS_SCR_LEN-2:0], scr_data[i]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			scr_state  <= '1; // Matches the descrambler reset state
			o_tx_valid <= 1'b0;
		end else begin
			o_tx_valid <= i_data_valid;
			if (i_data_valid) begin
				scr_state <= scr_state_next;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_data_valid) begin
			o_tx_block <= {scr_data, `PCS_SYNC_DATA};
		end
	end

endmodule

// ==== prbs11_lane.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module prbs11_lane #(
	parameter pcs_pattern_pkg::lfsr_t SEED     = 11'h7FE,
	parameter int                     HIGH_LIM = 10,
	parameter int                     LOW_LIM  = 3
) (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,
	output pcs_pattern_pkg::byte_t  o_sequence
);

	logic [`PCS_PRBS_LEN-1:0] lfsr_state;
	logic                     lfsr_feedback;

	// The window must be one full byte inside the register
	if ((HIGH_LIM - LOW_LIM + 1 != `PCS_NB_BYTE) || (HIGH_LIM >= `PCS_PRBS_LEN) ||
		(LOW_LIM < 0)) begin : g_bad_window
		$error("prbs11_lane: window %0d..%0d is not one byte of the LFSR", HIGH_LIM, LOW_LIM);
	end

	assign lfsr_feedback = lfsr_state[10] ^ lfsr_state[8]; // x^11 + x^9 + 1

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			lfsr_state <= SEED;
		end else if (i_enable) begin
			lfsr_state <= {lfsr_state[`PCS_PRBS_LEN-2:0], lfsr_feedback};
		end
	end

	assign o_sequence = lfsr_state[HIGH_LIM:LOW_LIM];

endmodule

// ==== project.f ====
+incdir+.
pcs_pattern_pkg.sv
prbs11_lane.sv
data_generator.sv
pcs_scrambler.sv
pcs_descrambler.sv
pattern_checker.sv
pcs_pattern_top.sv
pcs_pattern_sva.sv
tb_pcs_pattern.sv

// ==== tb_pcs_pattern.sv ====
`timescale 1ns/1ps
`include "pcs_pattern_settings.svh"

module tb_pcs_pattern;
	import pcs_pattern_pkg::*;

	localparam lfsr_t LANE_SEED [8] = '{11'h7FE, 11'h7BE, 11'h2AA, 11'h4ED,
		11'h3AA, 11'h7AE, 11'h5CA, 11'h2DC};
	localparam int LANE_LO [8] = '{3, 0, 2, 3, 3, 1, 3, 2};

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_enable;
	logic i_rx_valid;
	coded_t i_rx_block;
	coded_t o_tx_block;
	logic o_tx_valid;
	logic o_locked;
	count_t o_err_blocks;
	count_t o_err_bits;
	count_t o_hdr_errors;

	lfsr_t tx_lane [8];
	lfsr_t rx_lane [8];
	scr_state_t tx_scr = '1;
	scr_state_t rx_scr = '1;
	count_t exp_bits = '0;
	count_t exp_blocks = '0;
	count_t exp_hdr = '0;
	logic exp_locked = 1'b0;
	logic [3:0] lock_hist = '0;
	int good_run = 0;
	int bad_run = 0;
	int rx_count = 0;
	logic [1:0] en_hist = '0;
	logic flip_req = 1'b0;
	int flip_bit = 0;
	int hdr_bad_left = 0;
	logic [1:0] hdr_mask = 2'b11;
	logic [31:0] rng = 32'h6427_9a58;
	int errors = 0;
	int tests = 0;
	int tests_failed = 0;
	int test_base = 0;

	pcs_pattern_top dut_i (.*);

	always #10 i_clock = ~i_clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic lfsr_t lfsr_next(input lfsr_t s);
		return {s[9:0], s[10] ^ s[8]};
	endfunction

	// History h holds the 58 old line bits first, then the new ones
	function automatic block_t scramble(input block_t d, input scr_state_t st);
		logic [121:0] h;
		h = '0;
		for (int j = 0; j < 58; j++) h[57-j] = st[j];
		for (int i = 0; i < 64; i++) h[58+i] = d[i] ^ h[i+19] ^ h[i];
		return h[121:58];
	endfunction

	function automatic block_t descramble(input block_t r, input scr_state_t st);
		logic [121:0] h;
		block_t d;
		h = {r, 58'b0};
		for (int j = 0; j < 58; j++) h[57-j] = st[j];
		for (int i = 0; i < 64; i++) d[i] = r[i] ^ h[i+19] ^ h[i];
		return d;
	endfunction

	function automatic scr_state_t state_after(input block_t line_bits);
		scr_state_t st;
		for (int j = 0; j < 58; j++) st[j] = line_bits[63-j];
		return st;
	endfunction

	task automatic check(input string name, input logic [65:0] exp, input logic [65:0] act);
		if (exp !== act) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic model_rx(input coded_t line);
		block_t gen;
		block_t diff;
		logic good;
		for (int k = 0; k < 8; k++) begin
			rx_lane[k] = lfsr_next(rx_lane[k]);
			gen[8*k +: 8] = byte_t'(rx_lane[k] >> LANE_LO[k]);
		end
		diff = descramble(line[65:2], rx_scr) ^ gen;
		rx_scr = state_after(line[65:2]);
		exp_bits += $countones(diff);
		exp_blocks += (diff != 0);
		good = (line[1:0] == 2'b01);
		exp_hdr += !good;
		good_run = good ? good_run + 1 : 0;
		bad_run = good ? 0 : bad_run + 1;
		if (!exp_locked && good_run >= `PCS_LOCK_GOOD) begin
			exp_locked = 1'b1;
			bad_run = 0;
		end else if (exp_locked && bad_run >= `PCS_LOCK_BAD) begin
			exp_locked = 1'b0;
			good_run = 0;
		end
		rx_count++;
	endtask

	// Loops the transmit output back with optional injection and sees the DUT outputs before the edge
	always @(posedge i_clock) begin : loopback
		coded_t mask;
		mask = '0;
		if (o_tx_valid) begin
			if (flip_req) begin
				mask[flip_bit] = 1'b1;
				flip_req = 1'b0;
			end else if (hdr_bad_left > 0) begin
				mask[1:0] = hdr_mask;
				hdr_bad_left--;
			end
			model_rx(o_tx_block ^ mask);
		end
		lock_hist = {lock_hist[2:0], exp_locked}; // o_locked follows the model three edges later
		i_rx_block <= o_tx_block ^ mask;
		i_rx_valid <= o_tx_valid;
	end

	always @(negedge i_clock) begin : output_compare
		block_t raw;
		if (!i_reset) begin
			check("o_tx_valid", 66'(en_hist[1]), 66'(o_tx_valid));
			check("o_locked", 66'(lock_hist[3]), 66'(o_locked));
			if (o_tx_valid) begin
				for (int k = 0; k < 8; k++) begin
					tx_lane[k] = lfsr_next(tx_lane[k]);
					raw[8*k +: 8] = byte_t'(tx_lane[k] >> LANE_LO[k]);
				end
				raw = scramble(raw, tx_scr);
				tx_scr = state_after(raw);
				check("o_tx_block", {raw, 2'b01}, o_tx_block);
			end
		end
		en_hist = {en_hist[0], i_enable};
	end

	task automatic drive_enable(input logic value);
		@(posedge i_clock);
		i_enable <= value;
	endtask

	task automatic wait_blocks(input int n);
		int target;
		int t;
		target = rx_count + n;
		for (t = 0; t < 200 && rx_count < target; t++) @(negedge i_clock);
		if (rx_count < target) begin
			$display("Timeout while waiting for looped back blocks");
			errors++;
		end
	endtask

	task automatic wait_injected();
		int t;
		for (t = 0; t < 200 && (flip_req || hdr_bad_left > 0); t++) @(negedge i_clock);
		if (flip_req || hdr_bad_left > 0) begin
			$display("Timeout while waiting for an injected error to go out");
			errors++;
		end
	endtask

	// Waits until the link is idle, then compares all receive results
	task automatic wait_settled();
		int t;
		int idle;
		idle = 0;
		for (t = 0; t < 300 && idle < 4; t++) begin
			@(negedge i_clock);
			idle = (o_tx_valid || i_rx_valid || i_enable) ? 0 : idle + 1;
		end
		if (idle < 4) begin
			$display("Timeout while waiting for the link to go idle");
			errors++;
		end
		check("o_err_bits", 66'(exp_bits), 66'(o_err_bits));
		check("o_err_blocks", 66'(exp_blocks), 66'(o_err_blocks));
		check("o_hdr_errors", 66'(exp_hdr), 66'(o_hdr_errors));
		check("o_locked", 66'(exp_locked), 66'(o_locked));
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_base) tests_failed++;
		$display("Test %0d %s: %s", tests, name, (errors == test_base) ? "ok" : "failed");
		test_base = errors;
	endtask

	initial begin : watchdog
		#2ms;
		$display("Simulation ran too long and was stopped");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		count_t bits_base;
		count_t hdr_base;
		for (int k = 0; k < 8; k++) begin
			tx_lane[k] = LANE_SEED[k];
			rx_lane[k] = LANE_SEED[k];
		end
		i_reset = 1'b1;
		i_enable = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_block = '0;
		repeat (10) @(posedge i_clock);
		i_reset <= 1'b0;

		@(negedge i_clock);
		check("o_tx_valid", 66'(0), 66'(o_tx_valid));
		check("o_locked", 66'(0), 66'(o_locked));
		check("o_err_bits", 66'(0), 66'(o_err_bits));
		check("o_err_blocks", 66'(0), 66'(o_err_blocks));
		check("o_hdr_errors", 66'(0), 66'(o_hdr_errors));
		end_test("reset state");

		drive_enable(1'b1);
		wait_blocks(40);
		drive_enable(1'b0);
		wait_settled();
		end_test("continuous transmit");

		for (int c = 0; c < 80; c++) begin
			rng = xorshift32(rng);
			drive_enable(rng[0]);
		end
		drive_enable(1'b0);
		wait_settled();
		check("o_err_bits", 66'(0), 66'(o_err_bits));
		check("o_locked", 66'(1), 66'(o_locked));
		end_test("gated transmit");

		bits_base = exp_bits;
		drive_enable(1'b1);
		for (int f = 0; f < 6; f++) begin
			@(negedge i_clock);
			rng = xorshift32(rng);
			flip_bit = 2 + int'(rng % 64);
			flip_req = 1'b1;
			wait_injected();
			wait_blocks(3);
		end
		drive_enable(1'b0);
		wait_settled();
		check("o_err_bits", 66'(bits_base + 18), 66'(o_err_bits));
		end_test("payload bit flips");

		hdr_base = exp_hdr;
		drive_enable(1'b1);
		@(negedge i_clock);
		rng = xorshift32(rng);
		hdr_mask = 2'(rng % 3 + 1);
		hdr_bad_left = 4;
		wait_injected();
		drive_enable(1'b0);
		wait_settled();
		check("o_hdr_errors", 66'(hdr_base + 4), 66'(o_hdr_errors));
		check("o_locked", 66'(0), 66'(o_locked));
		drive_enable(1'b1);
		wait_blocks(10);
		drive_enable(1'b0);
		wait_settled();
		check("o_locked", 66'(1), 66'(o_locked));
		end_test("header errors and lock");

		$display("Tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
